// ==== attosoc.f ====
attosoc_pkg.sv
boot_rom.sv
led_port.sv
bus_mux.sv
attosoc_bus.sv
tb_clock.sv
attosoc_bus_tb.sv

// ==== attosoc_bus.sv ====
// Memory-bus subsystem of the small SoC, without the processor.
// The master drives valid, address, write data and strobes, and holds
// them until ready comes back in the same cycle. Region 0x00 reaches the
// boot ROM, 0x02 and above reach the LED port, and 0x01 is left
// unanswered. Only instances and wires live here.

`timescale 1ns/100ps
`default_nettype none

module attosoc_bus (
	input  logic                clk,
	input  logic                reset,
	input  logic                mem_valid,
	input  attosoc_pkg::addr_t  mem_addr,
	input  attosoc_pkg::word_t  mem_wdata,
	input  attosoc_pkg::strb_t  mem_wstrb,
	output logic                mem_ready,
	output attosoc_pkg::word_t  mem_rdata,
	output attosoc_pkg::led_t   led
);

	import attosoc_pkg::*;

	// Slave answers into the combiner.
	logic  rom_sel;
	word_t rom_rdata;
	logic  io_sel;
	word_t io_rdata;

	// Boot ROM.
	// Combinational, ignores writes.
	boot_rom boot_rom_inst (
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.rom_sel   (rom_sel),
		.rom_rdata (rom_rdata)
	);

	// LED port.
	// Only clocked state in the subsystem.
	led_port led_port_inst (
		.clk       (clk),
		.reset     (reset),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.io_sel    (io_sel),
		.io_rdata  (io_rdata),
		.led       (led)
	);

	// Single response to the master.
	bus_mux bus_mux_inst (
		.clk       (clk),
		.rom_sel   (rom_sel),
		.rom_rdata (rom_rdata),
		.io_sel    (io_sel),
		.io_rdata  (io_rdata),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== attosoc_bus_tb.sv ====
// Testbench for the memory-bus subsystem.
// Plays the bus master with LFSR-driven stimulus, driven on falling edges,
// and checks ready, read data and the LED byte against a model built from
// firmware.hex and the address map. Stops at the first mismatch.

`timescale 1ns/100ps
`default_nettype none

module attosoc_bus_tb;

	import attosoc_pkg::*;

	localparam logic [15:0] LFSR_SEED = 16'd15;
	localparam logic [15:0] LFSR_TAPS = 16'hb400;
	// Cycles a master waits for ready before giving up.
	localparam int TIMEOUT_CYCLES = 20;

	logic  clk;
	logic  reset;
	logic  mem_valid;
	addr_t mem_addr;
	word_t mem_wdata;
	strb_t mem_wstrb;
	logic  mem_ready;
	word_t mem_rdata;
	led_t  led;

	// Model state.
	logic [7:0]  model_rom [0:ROM_BYTES-1];
	led_t        model_led;
	logic [15:0] lfsr_state;

	tb_clock tb_clock_inst (
		.clk (clk)
	);

	attosoc_bus attosoc_bus_inst (
		.clk       (clk),
		.reset     (reset),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata),
		.led       (led)
	);

	// One shift of the Galois LFSR.
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	// Collects count bits, one LFSR step per bit.
	function automatic word_t random_bits(input int count);
		word_t value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Little-endian word from the model image, wrapping at the ROM end.
	function automatic word_t rom_word(input addr_t addr);
		int base;
		base = int'(addr % addr_t'(ROM_BYTES));
		return {model_rom[(base + 3) % ROM_BYTES], model_rom[(base + 2) % ROM_BYTES],
			model_rom[(base + 1) % ROM_BYTES], model_rom[base]};
	endfunction

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_value(input string test_name, input word_t expected,
		input word_t actual);
		if (actual !== expected) begin
			stop_on_failure($sformatf("CHECK FAILED %s: expected 0x%08h, actual 0x%08h",
				test_name, expected, actual));
		end
	endtask

	// Answer must come in the first cycle of the access.
	task automatic require_ready(input string test_name, input int ready_cycle);
		if (ready_cycle == 0) begin
			stop_on_failure({test_name, ": no ready before the timeout"});
		end
		check_value({test_name, " ready cycle"}, word_t'(1), word_t'(ready_cycle));
	endtask

	// One bus access, held until ready or the timeout.
	// Ready and data are sampled a quarter period after the falling edge.
	// Returns at the falling edge after the completing rising edge.
	task automatic bus_access(input addr_t addr, input word_t wdata, input strb_t wstrb,
		input int limit, output int ready_cycle, output word_t rdata);
		int cycle;
		ready_cycle = 0;
		rdata = '0;
		cycle = 0;
		@(negedge clk);
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = wstrb;
		while (ready_cycle == 0 && cycle < limit) begin
			cycle++;
			#2;
			if (mem_ready) begin
				ready_cycle = cycle;
				rdata = mem_rdata;
			end
			@(negedge clk);
		end
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
	endtask

	initial begin
		addr_t addr;
		word_t wdata;
		word_t rdata;
		strb_t wstrb;
		int    ready_cycle;

		reset = 1'b1;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		lfsr_state = LFSR_SEED;
		model_led = '0;
		$readmemh("firmware.hex", model_rom);

		repeat (8) @(negedge clk);
		reset = 1'b0;

		// Idle bus after reset.
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			#2;
			check_value("reset led", word_t'(8'h00), word_t'(led));
			check_value("idle ready", word_t'(1'b0), word_t'(mem_ready));
		end

		// ROM reads at random byte offsets.
		for (int i = 0; i < 32; i++) begin
			addr = random_bits(32);
			addr[REGION_LSB +: 8] = REGION_ROM;
			// First reads start in the last four bytes, across the wrap.
			if (i < 4) begin
				addr[7:0] = 8'(ROM_BYTES - 4 + i);
			end
			bus_access(addr, '0, '0, TIMEOUT_CYCLES, ready_cycle, rdata);
			require_ready($sformatf("rom read %0d", i), ready_cycle);
			check_value($sformatf("rom read %0d data", i), rom_word(addr), rdata);
		end

		// I/O writes, about half with lane 0 enabled.
		for (int i = 0; i < 32; i++) begin
			addr = random_bits(32);
			if (addr[REGION_LSB +: 8] < REGION_IO_MIN) begin
				addr[REGION_LSB +: 8] = REGION_IO_MIN;
			end
			wdata = random_bits(32);
			wstrb = strb_t'(random_bits(4));
			bus_access(addr, wdata, wstrb, TIMEOUT_CYCLES, ready_cycle, rdata);
			require_ready($sformatf("io write %0d", i), ready_cycle);
			if (wstrb[0]) begin
				model_led = ~wdata[7:0];
			end
			check_value($sformatf("io write %0d led", i), word_t'(model_led), word_t'(led));
		end

		// I/O reads give back the stored byte.
		for (int i = 0; i < 16; i++) begin
			addr = random_bits(32);
			if (addr[REGION_LSB +: 8] < REGION_IO_MIN) begin
				addr[REGION_LSB +: 8] = REGION_IO_MIN;
			end
			bus_access(addr, '0, '0, TIMEOUT_CYCLES, ready_cycle, rdata);
			require_ready($sformatf("io read %0d", i), ready_cycle);
			check_value($sformatf("io read %0d data", i), word_t'(model_led), rdata);
		end

		// ROM writes are answered and leave the image alone.
		for (int i = 0; i < 8; i++) begin
			addr = random_bits(32);
			addr[REGION_LSB +: 8] = REGION_ROM;
			wdata = random_bits(32);
			wstrb = strb_t'(random_bits(4)) | 4'b0001;
			bus_access(addr, wdata, wstrb, TIMEOUT_CYCLES, ready_cycle, rdata);
			require_ready($sformatf("rom write %0d", i), ready_cycle);
			check_value($sformatf("rom write %0d led", i), word_t'(model_led), word_t'(led));
			bus_access(addr, '0, '0, TIMEOUT_CYCLES, ready_cycle, rdata);
			require_ready($sformatf("rom reread %0d", i), ready_cycle);
			check_value($sformatf("rom reread %0d data", i), rom_word(addr), rdata);
		end

		// Unmapped region 0x01, timeout is the expected outcome.
		addr = random_bits(32);
		addr[REGION_LSB +: 8] = 8'h01;
		wdata = random_bits(32);
		bus_access(addr, wdata, 4'b1111, TIMEOUT_CYCLES, ready_cycle, rdata);
		check_value("unmapped ready", word_t'(0), word_t'(ready_cycle));
		check_value("unmapped led", word_t'(model_led), word_t'(led));

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== attosoc_pkg.sv ====
// Shared types and constants for the memory-bus subsystem.
// Covers the bus vector widths, the boot ROM size and the region codes
// held in address bits 31..24. Imported by every RTL module and by the
// testbench model, so the address map is defined only here.

`default_nettype none

package attosoc_pkg;

	// Bus vectors.
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;

	// LED output port.
	typedef logic [7:0] led_t;

	// Region field in the top address byte.
	typedef logic [7:0] region_t;

	// Lowest address bit of the region field.
	localparam int REGION_LSB = 24;

	// Boot ROM geometry.
	localparam int ROM_BYTES = 256;
	// Byte index width, so index sums wrap at the ROM size.
	localparam int ROM_AW = $clog2(ROM_BYTES);
	typedef logic [ROM_AW-1:0] rom_idx_t;

	// Region codes.
	// 0x01 lies between them and is left unmapped.
	localparam region_t REGION_ROM    = 8'h00;
	localparam region_t REGION_IO_MIN = 8'h02;

	// Pulls the region code out of a bus address.
	function automatic region_t region_of(input addr_t addr);
		return addr[REGION_LSB +: $bits(region_t)];
	endfunction

endpackage

`default_nettype wire

// ==== boot_rom.sv ====
// Boot ROM slave for the master's memory bus.
// Holds the firmware image loaded from firmware.hex at elaboration and
// answers every access in the ROM region in the same cycle. Reads return
// a little-endian word starting at any byte address; the byte index wraps
// at the end of the ROM. Writes are acknowledged and ignored.

`timescale 1ns/100ps
`default_nettype none

module boot_rom (
	input  logic                mem_valid,
	input  attosoc_pkg::addr_t  mem_addr,
	output logic                rom_sel,
	output attosoc_pkg::word_t  rom_rdata
);

	import attosoc_pkg::*;

	// Byte-wide image of the firmware.
	logic [7:0] rom [0:ROM_BYTES-1];

	// Index of the addressed byte and of the three bytes after it.
	rom_idx_t idx0;
	rom_idx_t idx1;
	rom_idx_t idx2;
	rom_idx_t idx3;

	// Contents come only from the hex file.
	// Four bytes per line, lowest address first.
	initial begin
		$readmemh("firmware.hex", rom);
	end

	// Low address bits pick the first byte.
	assign idx0 = mem_addr[ROM_AW-1:0];

	// Index sums stay ROM_AW bits wide.
	// Reads near the top of the ROM wrap to byte 0.
	assign idx1 = idx0 + rom_idx_t'(1);
	assign idx2 = idx0 + rom_idx_t'(2);
	assign idx3 = idx0 + rom_idx_t'(3);

	// Little-endian assembly.
	// Lowest address lands in the lowest byte lane.
	assign rom_rdata = {rom[idx3], rom[idx2], rom[idx1], rom[idx0]};

	// Select only in the ROM region.
	// Also the ready for this slave, since the ROM never stalls.
	// Upper address bits below the region field are don't-care,
	// so the image repeats through the region.
	assign rom_sel = mem_valid && (region_of(mem_addr) == REGION_ROM);

endmodule

`default_nettype wire

// ==== bus_mux.sv ====
// Response combiner for the memory bus.
// Merges the selects and read data of the boot ROM and the LED port into
// the single ready and read-data answer the master sees. Both slaves
// answer in the cycle they are selected, so ready is just the OR of the
// selects. clk only samples the overlap check.

`timescale 1ns/100ps
`default_nettype none

module bus_mux (
	input  logic                clk,
	input  logic                rom_sel,
	input  attosoc_pkg::word_t  rom_rdata,
	input  logic                io_sel,
	input  attosoc_pkg::word_t  io_rdata,
	output logic                mem_ready,
	output attosoc_pkg::word_t  mem_rdata
);

	import attosoc_pkg::*;

	// Ready when either slave claims the access.
	// Region 0x01 selects neither, so it is never answered.
	assign mem_ready = rom_sel || io_sel;

	// Read data from the selected slave.
	// Zero when idle or unmapped, so the bus never floats.
	always_comb begin
		if (rom_sel) begin
			mem_rdata = rom_rdata;
		end else if (io_sel) begin
			mem_rdata = io_rdata;
		end else begin
			mem_rdata = '0;
		end
	end

	// The two slaves decode disjoint regions.
	// A hit on both would mean the address map in the slaves has drifted.
	a_sel_disjoint: assert property (
		@(posedge clk) !(rom_sel && io_sel)
	) else $error("ROM and I/O selected in the same cycle");

endmodule

`default_nettype wire

// ==== firmware.hex ====
// Boot ROM image, one byte per column, lowest byte address first.
// Four bytes per line, so line n holds bytes 4n to 4n+3.
a5 a4 a7 a6
a1 a0 a3 a2
ad ac af ae
a9 a8 ab aa
b5 b4 b7 b6
b1 b0 b3 b2
bd bc bf be
b9 b8 bb ba
85 84 87 86
81 80 83 82
8d 8c 8f 8e
89 88 8b 8a
95 94 97 96
91 90 93 92
9d 9c 9f 9e
99 98 9b 9a
e5 e4 e7 e6
e1 e0 e3 e2
ed ec ef ee
e9 e8 eb ea
f5 f4 f7 f6
f1 f0 f3 f2
fd fc ff fe
f9 f8 fb fa
c5 c4 c7 c6
c1 c0 c3 c2
cd cc cf ce
c9 c8 cb ca
d5 d4 d7 d6
d1 d0 d3 d2
dd dc df de
d9 d8 db da
25 24 27 26
21 20 23 22
2d 2c 2f 2e
29 28 2b 2a
35 34 37 36
31 30 33 32
3d 3c 3f 3e
39 38 3b 3a
05 04 07 06
01 00 03 02
0d 0c 0f 0e
09 08 0b 0a
15 14 17 16
11 10 13 12
1d 1c 1f 1e
19 18 1b 1a
65 64 67 66
61 60 63 62
6d 6c 6f 6e
69 68 6b 6a
75 74 77 76
71 70 73 72
7d 7c 7f 7e
79 78 7b 7a
45 44 47 46
41 40 43 42
4d 4c 4f 4e
49 48 4b 4a
55 54 57 56
51 50 53 52
5d 5c 5f 5e
59 58 5b 5a

// ==== led_port.sv ====
// LED output port on the I/O side of the memory bus.
// Any access with region code REGION_IO_MIN or above selects it. A write
// with strobe bit 0 set stores the inverted low data byte, which drives
// the LEDs from the next cycle on. Reads return the stored byte
// zero-extended to a bus word.

`timescale 1ns/100ps
`default_nettype none

module led_port (
	input  logic                clk,
	input  logic                reset,
	input  logic                mem_valid,
	input  attosoc_pkg::addr_t  mem_addr,
	input  attosoc_pkg::word_t  mem_wdata,
	input  attosoc_pkg::strb_t  mem_wstrb,
	output logic                io_sel,
	output attosoc_pkg::word_t  io_rdata,
	output attosoc_pkg::led_t   led
);

	import attosoc_pkg::*;

	// Write into the LED byte lane this cycle.
	logic led_we;

	// Whole I/O space maps onto the one register.
	// No further address decode below the region field.
	assign io_sel = mem_valid && (region_of(mem_addr) >= REGION_IO_MIN);

	// Only lane 0 carries the LED byte.
	// Writes on the other lanes are answered and dropped.
	assign led_we = io_sel && mem_wstrb[0];

	// LED register.
	// LEDs are active low on the board, hence the inversion.
	always_ff @(posedge clk) begin
		if (reset) begin
			led <= '0;
		end else if (led_we) begin
			led <= ~mem_wdata[$bits(led_t)-1:0];
		end
	end

	// Readback of the stored byte.
	// Zero-extended, upper lanes read as 0.
	assign io_rdata = word_t'(led);

	// LED only moves on the edge that ends a lane-0 I/O write,
	// or while coming out of reset.
	a_led_write_only: assert property (
		@(posedge clk)
		(led != $past(led)) |-> ($past(reset) || $past(led_we))
	) else $error("led changed without a selected lane-0 write");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bus testbench with Verilator and runs it.
# Exit status is 0 only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module attosoc_bus_tb -f attosoc.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vattosoc_bus_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qF 'All tests passed!'; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// ==== tb_clock.sv ====
// Free-running clock source for the bus testbench.
// Starts low and toggles every half period, 8 ns per cycle.

`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic clk
);

	// Half of the 8 ns period.
	localparam int HALF_PERIOD = 4;

	initial begin
		clk = 1'b0;
	end

	always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire
